// File: src/core_pkg.sv
// ISA-level definitions shared across the core
package core_pkg;

    // Data and address width
    localparam int unsigned XLEN = 32;

    // Instruction word field positions
    localparam int unsigned RD_LSB     = 7;   // rd in bits 11..7
    localparam int unsigned FUNCT3_LSB = 12;  // funct3 in bits 14..12

    // Trap cause as recorded at commit
    typedef enum logic [1:0] {
        CAUSE_ILLEGAL  = 2'd0,  // Flagged by decode
        CAUSE_DIV_ZERO = 2'd1,  // Divide by zero from mul/div
        CAUSE_ACCESS   = 2'd2,  // Load/store access fault
        CAUSE_MISALIGN = 2'd3   // Load/store misaligned address
    } cause_t;

endpackage

// File: src/rob_pkg.sv
// Reorder buffer geometry and entry layout
package rob_pkg;

    // Buffer geometry
    localparam int unsigned ROB_DEPTH = 64;
    localparam int unsigned TAG_W     = 6;

    // Slot index handed to decode as the instruction tag
    typedef logic [TAG_W-1:0] tag_t;

    // Occupancy needs one extra bit to tell full from empty
    typedef logic [TAG_W:0] count_t;

    // One buffer slot
    typedef struct packed {
        logic                       valid;      // Slot holds an instruction
        logic                       ready;      // Result or exception known
        logic                       exc;        // Traps when it reaches the head
        core_pkg::cause_t           cause;      // Meaningful only with exc
        logic                       reg_write;  // Writes rd at commit
        logic                       mem_write;  // Store at commit
        logic                       mret;       // Return from trap
        logic [core_pkg::XLEN-1:0]  value;      // Result, or branch target
        logic [core_pkg::XLEN-1:0]  addr;       // Memory address
        logic [core_pkg::XLEN-1:0]  inst;       // Raw instruction word
        logic [core_pkg::XLEN-1:0]  pc;         // Instruction address
    } rob_entry_t;

endpackage

// File: src/rob_if.sv
`timescale 1ns/100ps

// Head of the buffer as seen by the retire logic
interface rob_head_if;

    rob_pkg::rob_entry_t head_entry;  // Slot at the head pointer
    logic                head_valid;  // Buffer not empty
    logic                retire;      // Frees the head slot
    logic                flush;       // Empties the whole buffer

    modport store (
        output head_entry,
        output head_valid,
        input  retire,
        input  flush
    );

    modport commit (
        input  head_entry,
        input  head_valid,
        output retire,
        output flush
    );

endinterface

// Trap capture and return address
interface trap_if;

    logic                      take;    // Trap taken this cycle
    core_pkg::cause_t          cause;   // Cause of the trap
    logic [core_pkg::XLEN-1:0] epc;     // PC of the faulting instruction
    logic [core_pkg::XLEN-1:0] ret_pc;  // Stored trap PC for mret

    modport commit (
        output take,
        output cause,
        output epc,
        input  ret_pc
    );

    modport regs (
        input  take,
        input  cause,
        input  epc,
        output ret_pc
    );

endinterface

// File: src/rob_store.sv
`timescale 1ns/100ps

module rob_store (
    input  logic                      clk,
    input  logic                      rst,

    // Dispatch from decode
    input  logic                      disp_valid,
    input  logic [core_pkg::XLEN-1:0] disp_inst,
    input  logic [core_pkg::XLEN-1:0] disp_pc,
    input  logic                      disp_reg_write,
    input  logic                      disp_mem_write,
    input  logic                      disp_mret,
    input  logic                      disp_exc,
    output rob_pkg::tag_t             disp_tag,
    output logic                      full,

    // ALU completion
    input  logic                      alu_done,
    input  rob_pkg::tag_t             alu_tag,
    input  logic [core_pkg::XLEN-1:0] alu_value,

    // Mul/div completion
    input  logic                      md_done,
    input  rob_pkg::tag_t             md_tag,
    input  logic [core_pkg::XLEN-1:0] md_value,
    input  logic                      md_div_zero,

    // Load/store completion
    input  logic                      mem_done,
    input  rob_pkg::tag_t             mem_tag,
    input  logic [core_pkg::XLEN-1:0] mem_value,
    input  logic [core_pkg::XLEN-1:0] mem_addr,
    input  logic                      mem_fault,
    input  logic                      mem_misalign,

    // Branch completion
    input  logic                      br_done,
    input  rob_pkg::tag_t             br_tag,
    input  logic [core_pkg::XLEN-1:0] br_target,
    input  logic                      br_mispredict,

    rob_head_if.store                 head
);

    rob_pkg::rob_entry_t entries [rob_pkg::ROB_DEPTH];

    rob_pkg::tag_t   head_ptr;
    rob_pkg::tag_t   tail_ptr;
    rob_pkg::count_t count;
    rob_pkg::count_t count_next;
    rob_pkg::count_t kept;       // Entries up to and including a mispredicted branch

    logic mispredict;
    logic alloc;

    // True when slot lies after br_slot in program order
    function automatic logic is_younger(rob_pkg::tag_t slot, rob_pkg::tag_t br_slot,
                                        rob_pkg::tag_t base);
        rob_pkg::tag_t slot_age;
        rob_pkg::tag_t br_age;
        slot_age = slot - base;
        br_age   = br_slot - base;
        return slot_age > br_age;
    endfunction

    assign mispredict = br_done && br_mispredict && entries[br_tag].valid;
    assign alloc      = disp_valid && !full && !head.flush && !mispredict;

    assign disp_tag = tail_ptr;
    assign full     = (count == rob_pkg::count_t'(rob_pkg::ROB_DEPTH));

    assign head.head_entry = entries[head_ptr];
    assign head.head_valid = (count != '0);

    always_comb begin
        kept = {1'b0, br_tag - head_ptr} + rob_pkg::count_t'(1);
        if (mispredict) begin
            count_next = kept - rob_pkg::count_t'(head.retire);
        end else begin
            count_next = count + rob_pkg::count_t'(alloc) - rob_pkg::count_t'(head.retire);
        end
    end

    always_ff @(posedge clk) begin
        if (rst || head.flush) begin  // Trap flush overrides everything
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
            for (int i = 0; i < rob_pkg::ROB_DEPTH; i++) begin
                entries[i].valid <= 1'b0;
                entries[i].ready <= 1'b0;
            end
        end else begin
            if (alu_done && entries[alu_tag].valid) begin
                entries[alu_tag].value <= alu_value;
                entries[alu_tag].ready <= 1'b1;
            end
            if (md_done && entries[md_tag].valid) begin
                entries[md_tag].value <= md_value;
                entries[md_tag].ready <= 1'b1;
                if (md_div_zero) begin
                    entries[md_tag].exc   <= 1'b1;
                    entries[md_tag].cause <= core_pkg::CAUSE_DIV_ZERO;
                end
            end
            if (mem_done && entries[mem_tag].valid) begin
                entries[mem_tag].value <= mem_value;
                entries[mem_tag].addr  <= mem_addr;
                entries[mem_tag].ready <= 1'b1;
                if (mem_fault) begin  // Access fault wins over misalignment
                    entries[mem_tag].exc   <= 1'b1;
                    entries[mem_tag].cause <= core_pkg::CAUSE_ACCESS;
                end else if (mem_misalign) begin
                    entries[mem_tag].exc   <= 1'b1;
                    entries[mem_tag].cause <= core_pkg::CAUSE_MISALIGN;
                end
            end
            if (br_done && entries[br_tag].valid) begin
                entries[br_tag].ready <= 1'b1;
                if (br_mispredict) begin
                    entries[br_tag].value <= br_target;  // Corrected target
                end
            end

            if (mispredict) begin
                tail_ptr <= br_tag + rob_pkg::tag_t'(1);
                for (int i = 0; i < rob_pkg::ROB_DEPTH; i++) begin
                    if (is_younger(rob_pkg::tag_t'(i), br_tag, head_ptr)) begin
                        entries[i].valid <= 1'b0;
                        entries[i].ready <= 1'b0;
                    end
                end
            end else if (alloc) begin
                entries[tail_ptr] <= '{
                    valid:     1'b1,
                    ready:     disp_exc,  // Decode exceptions need no execution
                    exc:       disp_exc,
                    cause:     core_pkg::CAUSE_ILLEGAL,
                    reg_write: disp_reg_write,
                    mem_write: disp_mem_write,
                    mret:      disp_mret,
                    value:     '0,
                    addr:      '0,
                    inst:      disp_inst,
                    pc:        disp_pc
                };
                tail_ptr <= tail_ptr + rob_pkg::tag_t'(1);
            end

            if (head.retire) begin
                entries[head_ptr].valid <= 1'b0;
                entries[head_ptr].ready <= 1'b0;
                head_ptr <= head_ptr + rob_pkg::tag_t'(1);
            end

            count <= count_next;
        end
    end

endmodule

// File: src/rob_commit.sv
`timescale 1ns/100ps

module rob_commit (
    input  logic                      clk,
    input  logic                      rst,

    rob_head_if.commit                head,
    trap_if.commit                    trap,

    // Retire towards register file and store port
    output logic                      cm_valid,
    output logic [core_pkg::XLEN-1:0] cm_value,
    output logic [4:0]                cm_dest,
    output logic [2:0]                cm_funct3,
    output logic                      cm_reg_write,
    output logic                      cm_mem_write,
    output logic [core_pkg::XLEN-1:0] cm_addr,
    output logic [core_pkg::XLEN-1:0] cm_pc,

    // Trap and return
    output logic                      trap_valid,
    output logic [core_pkg::XLEN-1:0] trap_epc,
    output core_pkg::cause_t          trap_cause,
    output logic                      mret_valid,
    output logic [core_pkg::XLEN-1:0] mret_pc
);

    logic head_ready;
    logic take_trap;
    logic do_retire;
    logic do_commit;
    logic do_mret;

    assign head_ready = head.head_valid && head.head_entry.ready;
    assign take_trap  = head_ready && head.head_entry.exc;   // Exception beats mret
    assign do_retire  = head_ready && !head.head_entry.exc;
    assign do_mret    = do_retire && head.head_entry.mret;
    assign do_commit  = do_retire && !head.head_entry.mret;

    assign head.retire = do_retire;
    assign head.flush  = take_trap;

    assign trap.take  = take_trap;
    assign trap.cause = head.head_entry.cause;
    assign trap.epc   = head.head_entry.pc;

    // Strobes and write enables
    always_ff @(posedge clk) begin
        if (rst) begin
            cm_valid     <= 1'b0;
            cm_reg_write <= 1'b0;
            cm_mem_write <= 1'b0;
            trap_valid   <= 1'b0;
            mret_valid   <= 1'b0;
        end else begin
            cm_valid     <= do_commit;
            cm_reg_write <= do_commit && head.head_entry.reg_write;
            cm_mem_write <= do_commit && head.head_entry.mem_write;
            trap_valid   <= take_trap;
            mret_valid   <= do_mret;
        end
    end

    // Payload, held until the next event of its kind
    always_ff @(posedge clk) begin
        if (do_commit) begin
            cm_value  <= head.head_entry.value;
            cm_dest   <= head.head_entry.inst[core_pkg::RD_LSB +: 5];
            cm_funct3 <= head.head_entry.inst[core_pkg::FUNCT3_LSB +: 3];
            cm_addr   <= head.head_entry.addr;
            cm_pc     <= head.head_entry.pc;
        end
        if (take_trap) begin
            trap_epc   <= head.head_entry.pc;
            trap_cause <= head.head_entry.cause;
        end
        if (do_mret) begin
            mret_pc <= trap.ret_pc;  // PC saved by the last trap
        end
    end

endmodule

// File: src/trap_regs.sv
`timescale 1ns/100ps

// Machine trap state: exception PC and cause
module trap_regs (
    input  logic   clk,
    input  logic   rst,

    trap_if.regs   trap
);

    logic [core_pkg::XLEN-1:0] epc_q;
    core_pkg::cause_t          cause_q;

    // Loaded once per trap, then stable until the next one
    always_ff @(posedge clk) begin
        if (rst) begin
            epc_q   <= '0;
            cause_q <= core_pkg::CAUSE_ILLEGAL;
        end else if (trap.take) begin
            epc_q   <= trap.epc;
            cause_q <= trap.cause;
        end
    end

    assign trap.ret_pc = epc_q;  // mret resumes at the trapping PC

endmodule

// File: src/rob_top.sv
`timescale 1ns/100ps

module rob_top (
    input  logic                      clk,
    input  logic                      rst,

    // Dispatch
    input  logic                      disp_valid,
    input  logic [core_pkg::XLEN-1:0] disp_inst,
    input  logic [core_pkg::XLEN-1:0] disp_pc,
    input  logic                      disp_reg_write,
    input  logic                      disp_mem_write,
    input  logic                      disp_mret,
    input  logic                      disp_exc,
    output rob_pkg::tag_t             disp_tag,
    output logic                      full,

    // Completions
    input  logic                      alu_done,
    input  rob_pkg::tag_t             alu_tag,
    input  logic [core_pkg::XLEN-1:0] alu_value,
    input  logic                      md_done,
    input  rob_pkg::tag_t             md_tag,
    input  logic [core_pkg::XLEN-1:0] md_value,
    input  logic                      md_div_zero,
    input  logic                      mem_done,
    input  rob_pkg::tag_t             mem_tag,
    input  logic [core_pkg::XLEN-1:0] mem_value,
    input  logic [core_pkg::XLEN-1:0] mem_addr,
    input  logic                      mem_fault,
    input  logic                      mem_misalign,
    input  logic                      br_done,
    input  rob_pkg::tag_t             br_tag,
    input  logic [core_pkg::XLEN-1:0] br_target,
    input  logic                      br_mispredict,

    // Commit
    output logic                      cm_valid,
    output logic [core_pkg::XLEN-1:0] cm_value,
    output logic [4:0]                cm_dest,
    output logic [2:0]                cm_funct3,
    output logic                      cm_reg_write,
    output logic                      cm_mem_write,
    output logic [core_pkg::XLEN-1:0] cm_addr,
    output logic [core_pkg::XLEN-1:0] cm_pc,

    // Trap and return
    output logic                      trap_valid,
    output logic [core_pkg::XLEN-1:0] trap_epc,
    output core_pkg::cause_t          trap_cause,
    output logic                      mret_valid,
    output logic [core_pkg::XLEN-1:0] mret_pc
);

    rob_head_if head_bus ();
    trap_if     trap_bus ();

    rob_store rob_store_i (
        .clk, .rst,
        .disp_valid, .disp_inst, .disp_pc, .disp_reg_write, .disp_mem_write,
        .disp_mret, .disp_exc, .disp_tag, .full,
        .alu_done, .alu_tag, .alu_value,
        .md_done, .md_tag, .md_value, .md_div_zero,
        .mem_done, .mem_tag, .mem_value, .mem_addr, .mem_fault, .mem_misalign,
        .br_done, .br_tag, .br_target, .br_mispredict,
        .head (head_bus.store)
    );

    rob_commit rob_commit_i (
        .clk, .rst,
        .head (head_bus.commit),
        .trap (trap_bus.commit),
        .cm_valid, .cm_value, .cm_dest, .cm_funct3, .cm_reg_write, .cm_mem_write,
        .cm_addr, .cm_pc,
        .trap_valid, .trap_epc, .trap_cause, .mret_valid, .mret_pc
    );

    trap_regs trap_regs_i (
        .clk, .rst,
        .trap (trap_bus.regs)
    );

endmodule

// File: testbench/rob_tb.sv
`timescale 1ns/100ps

module rob_tb;

    typedef logic [core_pkg::XLEN-1:0] word_t;

    localparam logic [1:0] KIND_COMMIT = 2'd0;
    localparam logic [1:0] KIND_TRAP   = 2'd1;
    localparam logic [1:0] KIND_MRET   = 2'd2;
    localparam int PORT_ALU   = 0;
    localparam int PORT_MD    = 1;
    localparam int PORT_MEM   = 2;
    localparam int PORT_BR    = 3;
    localparam int MAX_CYCLES = 3000;  // Six tests under 300 cycles each, plus margin

    // One expected retire event
    typedef struct packed {
        logic [1:0]       kind;
        word_t            inst;
        word_t            pc;
        word_t            value;  // Result, or mret target for KIND_MRET
        word_t            addr;
        logic [4:0]       dest;
        logic [2:0]       funct3;
        logic             reg_write;
        logic             mem_write;
        core_pkg::cause_t cause;
    } exp_t;

    logic clk = 1'b0;
    logic rst;
    logic disp_valid, disp_reg_write, disp_mem_write, disp_mret, disp_exc, full;
    logic alu_done, md_done, md_div_zero, mem_done, mem_fault, mem_misalign;
    logic br_done, br_mispredict;
    word_t disp_inst, disp_pc, alu_value, md_value, mem_value, mem_addr, br_target;
    rob_pkg::tag_t disp_tag, alu_tag, md_tag, mem_tag, br_tag;
    logic cm_valid, cm_reg_write, cm_mem_write, trap_valid, mret_valid;
    word_t cm_value, cm_addr, cm_pc, trap_epc, mret_pc;
    logic [4:0] cm_dest;
    logic [2:0] cm_funct3;
    core_pkg::cause_t trap_cause;

    exp_t  exp_q[$];     // Reference model, oldest first
    exp_t  exp_head;
    int    exp_cnt;
    int    seed;
    int    cycles;
    int    errors;
    int    events;
    int    tests_run;
    int    test_start_errors;
    string test_name;
    logic  commit_check, trap_check, mret_check;

    rob_top rob_top_i (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not end within %0d cycles", MAX_CYCLES);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // Retire the oldest expected item once its event has been on the outputs
    always @(posedge clk) begin
        if (!rst && (cm_valid || trap_valid || mret_valid) && exp_q.size() > 0) begin
            void'(exp_q.pop_front());
            events++;
            refresh_head();
        end
    end

    assign commit_check = cm_valid && exp_cnt > 0 && exp_head.kind == KIND_COMMIT;
    assign trap_check   = trap_valid && exp_cnt > 0 && exp_head.kind == KIND_TRAP;
    assign mret_check   = mret_valid && exp_cnt > 0 && exp_head.kind == KIND_MRET;

    // Outputs change on the rising edge, so checks run on the falling edge
    commit_expected: assert property (@(negedge clk) disable iff (rst) cm_valid |-> commit_check)
        else report_failure("a commit appeared where none was expected");
    trap_expected: assert property (@(negedge clk) disable iff (rst) trap_valid |-> trap_check)
        else report_failure("a trap appeared where none was expected");
    mret_expected: assert property (@(negedge clk) disable iff (rst) mret_valid |-> mret_check)
        else report_failure("an mret appeared where none was expected");
    commit_pc: assert property (@(negedge clk) disable iff (rst)
        commit_check |-> cm_pc == exp_head.pc) else report_mismatch("cm_pc", exp_head.pc, cm_pc);
    commit_value: assert property (@(negedge clk) disable iff (rst)
        commit_check |-> cm_value == exp_head.value)
        else report_mismatch("cm_value", exp_head.value, cm_value);
    commit_dest: assert property (@(negedge clk) disable iff (rst)
        commit_check |-> cm_dest == exp_head.dest)
        else report_mismatch("cm_dest", exp_head.dest, cm_dest);
    commit_funct3: assert property (@(negedge clk) disable iff (rst)
        commit_check |-> cm_funct3 == exp_head.funct3)
        else report_mismatch("cm_funct3", exp_head.funct3, cm_funct3);
    commit_reg_write: assert property (@(negedge clk) disable iff (rst)
        commit_check |-> cm_reg_write == exp_head.reg_write)
        else report_mismatch("cm_reg_write", exp_head.reg_write, cm_reg_write);
    commit_mem_write: assert property (@(negedge clk) disable iff (rst)
        commit_check |-> cm_mem_write == exp_head.mem_write)
        else report_mismatch("cm_mem_write", exp_head.mem_write, cm_mem_write);
    commit_addr: assert property (@(negedge clk) disable iff (rst)
        commit_check && exp_head.mem_write |-> cm_addr == exp_head.addr)
        else report_mismatch("cm_addr", exp_head.addr, cm_addr);
    trap_pc: assert property (@(negedge clk) disable iff (rst)
        trap_check |-> trap_epc == exp_head.pc)
        else report_mismatch("trap_epc", exp_head.pc, trap_epc);
    trap_code: assert property (@(negedge clk) disable iff (rst)
        trap_check |-> trap_cause == exp_head.cause)
        else report_mismatch("trap_cause", exp_head.cause, trap_cause);
    mret_target: assert property (@(negedge clk) disable iff (rst)
        mret_check |-> mret_pc == exp_head.value)
        else report_mismatch("mret_pc", exp_head.value, mret_pc);

    function automatic void refresh_head();
        exp_cnt  = exp_q.size();
        exp_head = (exp_cnt > 0) ? exp_q[0] : '0;
    endfunction

    task automatic report_mismatch(input string what, input word_t expected, input word_t actual);
        errors++;
        $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, expected, actual);
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("Test %s: %s", test_name, what);
    endtask

    task automatic check_value(input string what, input word_t expected, input word_t actual);
        assert (expected == actual) else report_mismatch(what, expected, actual);
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (8) next_cycle();
        exp_q.delete();
        refresh_head();
        rst = 1'b0;
    endtask

    // Idle outputs and an empty buffer
    task automatic check_reset_state();
        check_value("cm_valid after reset", 0, cm_valid);
        check_value("trap_valid after reset", 0, trap_valid);
        check_value("mret_valid after reset", 0, mret_valid);
        check_value("full after reset", 0, full);
        check_value("disp_tag after reset", 0, disp_tag);
    endtask

    // Expected commit with rd and funct3 cut from the instruction word
    function automatic exp_t make_item(input logic [1:0] kind, input word_t inst,
                                       input word_t pc, input word_t value);
        exp_t item;
        item           = '0;
        item.kind      = kind;
        item.inst      = inst;
        item.pc        = pc;
        item.value     = value;
        item.dest      = inst[11:7];
        item.funct3    = inst[14:12];
        item.reg_write = (kind == KIND_COMMIT);
        item.cause     = core_pkg::CAUSE_ILLEGAL;
        return item;
    endfunction

    task automatic dispatch(input exp_t item, input logic exc, input logic tracked,
                            output rob_pkg::tag_t tag);
        if (full) report_failure("dispatch attempted while the buffer is full");
        tag            = disp_tag;
        disp_valid     = 1'b1;
        disp_inst      = item.inst;
        disp_pc        = item.pc;
        disp_reg_write = item.reg_write;
        disp_mem_write = item.mem_write;
        disp_mret      = (item.kind == KIND_MRET);
        disp_exc       = exc;
        if (tracked) begin
            exp_q.push_back(item);
            refresh_head();
        end
        next_cycle();
        disp_valid = 1'b0;
        disp_mret  = 1'b0;
        disp_exc   = 1'b0;
    endtask

    // flag_a is div_zero, fault or mispredict; flag_b is misalign
    task automatic complete(input int port, input rob_pkg::tag_t tag, input word_t value,
                            input word_t addr, input logic flag_a, input logic flag_b);
        case (port)
            PORT_ALU: begin
                alu_done  = 1'b1;
                alu_tag   = tag;
                alu_value = value;
            end
            PORT_MD: begin
                md_done     = 1'b1;
                md_tag      = tag;
                md_value    = value;
                md_div_zero = flag_a;
            end
            PORT_MEM: begin
                mem_done     = 1'b1;
                mem_tag      = tag;
                mem_value    = value;
                mem_addr     = addr;
                mem_fault    = flag_a;
                mem_misalign = flag_b;
            end
            default: begin
                br_done       = 1'b1;
                br_tag        = tag;
                br_target     = value;
                br_mispredict = flag_a;
            end
        endcase
        next_cycle();
        {alu_done, md_done, mem_done, br_done} = '0;
        {md_div_zero, mem_fault, mem_misalign, br_mispredict} = '0;
    endtask

    task automatic wait_drained(input int limit);
        int n;
        n = 0;
        while (exp_cnt != 0 && n < limit) begin
            next_cycle();
            n++;
        end
        if (exp_cnt != 0) begin
            report_failure("expected retire events did not appear in time");
            exp_q.delete();
            refresh_head();
        end
        repeat (3) next_cycle();  // Room for stray events to show up
    endtask

    task automatic start_test(input string name);
        test_name         = name;
        test_start_errors = errors;
    endtask

    task automatic finish_test();
        tests_run++;
        $display("Test %s done, %0d errors", test_name, errors - test_start_errors);
    endtask

    task automatic test_in_order();
        rob_pkg::tag_t tags[20];
        word_t values[20];
        int ports[20];
        int order[20];
        int j;
        int tmp;
        start_test("in_order");
        for (int i = 0; i < 20; i++) begin
            values[i] = $random(seed);
            ports[i]  = $unsigned($random(seed)) % 3;
            order[i]  = i;
            dispatch(make_item(KIND_COMMIT, $random(seed), 32'h1000 + 4 * i, values[i]),
                     1'b0, 1'b1, tags[i]);
        end
        for (int i = 19; i > 0; i--) begin  // Shuffle the completion order
            j        = $unsigned($random(seed)) % (i + 1);
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (int k = 0; k < 20; k++) begin
            complete(ports[order[k]], tags[order[k]], values[order[k]], '0, 1'b0, 1'b0);
        end
        wait_drained(100);
        finish_test();
    endtask

    task automatic test_back_pressure();
        rob_pkg::tag_t tags[64];
        rob_pkg::tag_t held_tag;
        int n;
        start_test("back_pressure");
        for (int i = 0; i < 64; i++) begin
            dispatch(make_item(KIND_COMMIT, $random(seed), 32'h2000 + 4 * i, i),
                     1'b0, 1'b1, tags[i]);
        end
        check_value("full after 64 dispatches", 1, full);
        held_tag   = disp_tag;
        disp_valid = 1'b1;  // Extra dispatch, to be ignored
        disp_pc    = 32'h2f00;
        next_cycle();
        disp_valid = 1'b0;
        check_value("disp_tag after ignored dispatch", held_tag, disp_tag);
        check_value("full after ignored dispatch", 1, full);
        complete(PORT_ALU, tags[0], 0, '0, 1'b0, 1'b0);
        n = 0;
        while (full && n < 10) begin
            next_cycle();
            n++;
        end
        check_value("full after one retire", 0, full);
        for (int i = 1; i < 64; i++) begin
            complete(PORT_ALU, tags[i], i, '0, 1'b0, 1'b0);
        end
        wait_drained(100);
        finish_test();
    endtask

    task automatic test_traps();
        rob_pkg::tag_t tag_o;
        rob_pkg::tag_t tag_f;
        rob_pkg::tag_t tag_y;
        exp_t item;
        word_t pc;
        start_test("traps");
        for (int c = 0; c < 4; c++) begin
            pc = 32'h4000 + 32'h100 * c;
            dispatch(make_item(KIND_COMMIT, $random(seed), pc, 32'h55), 1'b0, 1'b1, tag_o);
            item       = make_item(KIND_TRAP, $random(seed), pc + 4, '0);
            item.cause = core_pkg::cause_t'(c);  // Loop index is the cause code
            dispatch(item, c == 0, 1'b1, tag_f);
            for (int y = 0; y < 2; y++) begin  // Younger, ready, but flushed
                dispatch(make_item(KIND_COMMIT, $random(seed), pc + 8 + 4 * y, '0),
                         1'b0, 1'b0, tag_y);
                complete(PORT_ALU, tag_y, 32'hdead, '0, 1'b0, 1'b0);
            end
            case (c)
                1: complete(PORT_MD, tag_f, '0, '0, 1'b1, 1'b0);
                2: complete(PORT_MEM, tag_f, '0, pc, 1'b1, 1'b0);
                3: complete(PORT_MEM, tag_f, '0, pc + 1, 1'b0, 1'b1);
                default: ;
            endcase
            complete(PORT_ALU, tag_o, 32'h55, '0, 1'b0, 1'b0);
            wait_drained(50);
            check_value("disp_tag after trap", 0, disp_tag);
        end
        finish_test();
    endtask

    task automatic test_mispredict();
        rob_pkg::tag_t tag_b;
        rob_pkg::tag_t tag_y;
        exp_t item;
        word_t target;
        start_test("mispredict");
        target         = $random(seed);
        item           = make_item(KIND_COMMIT, $random(seed), 32'h5000, target);
        item.reg_write = 1'b0;
        dispatch(item, 1'b0, 1'b1, tag_b);
        for (int y = 0; y < 3; y++) begin
            dispatch(make_item(KIND_COMMIT, $random(seed), 32'h5004 + 4 * y, '0),
                     1'b0, 1'b0, tag_y);
            complete(PORT_ALU, tag_y, 32'hbad, '0, 1'b0, 1'b0);
        end
        complete(PORT_BR, tag_b, target, '0, 1'b1, 1'b0);
        wait_drained(50);
        check_value("disp_tag after mispredict", rob_pkg::tag_t'(tag_b + 1), disp_tag);
        finish_test();
    endtask

    task automatic test_mret();
        rob_pkg::tag_t tag;
        exp_t item;
        start_test("mret");
        dispatch(make_item(KIND_TRAP, $random(seed), 32'h6000, '0), 1'b1, 1'b1, tag);
        wait_drained(50);
        item = make_item(KIND_MRET, 32'h30200073, 32'h6100, 32'h6000);  // Returns to trap PC
        dispatch(item, 1'b0, 1'b1, tag);
        complete(PORT_ALU, tag, '0, '0, 1'b0, 1'b0);
        wait_drained(50);
        finish_test();
    endtask

    task automatic test_store_reset();
        rob_pkg::tag_t tag;
        exp_t item;
        word_t addr;
        start_test("store_reset");
        addr           = word_t'($random(seed)) & ~word_t'(3);
        item           = make_item(KIND_COMMIT, 32'h00a12023, 32'h7000, 32'h77);  // sw
        item.reg_write = 1'b0;
        item.mem_write = 1'b1;
        item.addr      = addr;
        dispatch(item, 1'b0, 1'b1, tag);
        complete(PORT_MEM, tag, 32'h77, addr, 1'b0, 1'b0);
        wait_drained(50);
        dispatch(make_item(KIND_COMMIT, $random(seed), 32'h7004, '0), 1'b0, 1'b0, tag);
        apply_reset();  // Pending entry must vanish
        check_reset_state();
        repeat (5) next_cycle();
        finish_test();
    endtask

    initial begin
        seed   = 32'hbd98;
        cycles = 0;
        errors = 0;
        events = 0;
        tests_run = 0;
        test_name = "reset";
        rst = 1'b1;
        {disp_valid, disp_reg_write, disp_mem_write, disp_mret, disp_exc} = '0;
        {alu_done, md_done, md_div_zero, mem_done, mem_fault, mem_misalign} = '0;
        {br_done, br_mispredict} = '0;
        {disp_inst, disp_pc, alu_value, md_value, mem_value, mem_addr, br_target} = '0;
        {alu_tag, md_tag, mem_tag, br_tag} = '0;
        refresh_head();
        apply_reset();
        check_reset_state();  // Power-up state comes only from reset
        test_in_order();
        test_back_pressure();
        test_traps();
        test_mispredict();
        test_mret();
        test_store_reset();
        $display("Tests %0d, events checked %0d, errors %0d", tests_run, events, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: tb.f
src/core_pkg.sv
src/rob_pkg.sv
src/rob_if.sv
src/rob_store.sv
src/rob_commit.sv
src/trap_regs.sv
src/rob_top.sv
testbench/rob_tb.sv

// File: Bender.yml
package:
  name: rob

sources:
  - files:
      - src/core_pkg.sv
      - src/rob_pkg.sv
      - src/rob_if.sv
      - src/rob_store.sv
      - src/rob_commit.sv
      - src/trap_regs.sv
      - src/rob_top.sv
  - target: test
    files:
      - testbench/rob_tb.sv
